//--- design/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath widths
`define CORE_WORD_WIDTH        32
`define CORE_REG_ADDR_WIDTH    4
`define CORE_OFFSET_WIDTH      24
`define CORE_SHIFT_FIELD_WIDTH 12

// Instruction word fields
`define CORE_COND_HI   31
`define CORE_COND_LO   28
`define CORE_CLASS_HI  27
`define CORE_CLASS_LO  25
`define CORE_OPCODE_HI 24
`define CORE_OPCODE_LO 21
`define CORE_SBIT_POS  20
`define CORE_RN_HI     19
`define CORE_RN_LO     16
`define CORE_RD_HI     15
`define CORE_RD_LO     12
`define CORE_RM_HI     3
`define CORE_RM_LO     0
`define CORE_LINK_POS  24   // L bit of B/BL
`define CORE_BIT4_POS  4

`endif

//--- design/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

    // Data word and register number
    typedef logic [`CORE_WORD_WIDTH-1:0]     word_t;
    typedef logic [`CORE_REG_ADDR_WIDTH-1:0] regAddr_t;

    // Internal ALU operation
    // 0 add, 1 adc, 2 A-B, 3 A-B-C, 4 B-A, 5 B-A-C,
    // 6 and, 7 or, 8 xor, 9 pass A, 10 pass B, 11 not B, 12 A and not B
    typedef logic [3:0] aluOp_t;

    // N Z C V from high to low
    typedef logic [3:0] flags_t;

    // 0 rotated immediate, 3 shifted Rm
    typedef logic [1:0] shiftMode_t;

    // Standard condition field
    typedef logic [3:0] condCode_t;

    // Bits 11:0 of a data-processing word
    typedef logic [`CORE_SHIFT_FIELD_WIDTH-1:0] shiftField_t;

endpackage

//--- design/instrDecoder.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module instrDecoder (
    input  logic                  Clk,
    input  logic                  reset,
    input  logic                  InstrValid,
    input  core_pkg::word_t       Instr,
    input  core_pkg::word_t       RnValue,
    input  core_pkg::word_t       RmValue,
    output logic                  DecValid,
    output logic                  DecBranch,
    output core_pkg::aluOp_t      DecAluOp,
    output logic                  DecSetFlags,
    output logic                  DecWrite,
    output core_pkg::shiftMode_t  DecShiftMode,
    output core_pkg::shiftField_t DecShiftField,
    output core_pkg::condCode_t   DecCond,
    output logic                  DecLink,
    output core_pkg::word_t       DecOffset,
    output core_pkg::regAddr_t    DecDest,
    output core_pkg::word_t       DecRn,
    output core_pkg::word_t       DecRm
);

    logic [`CORE_CLASS_HI-`CORE_CLASS_LO:0]   instrClass;
    logic [`CORE_OPCODE_HI-`CORE_OPCODE_LO:0] opcode;
    logic [`CORE_OFFSET_WIDTH-1:0]            branchImm;
    logic                                     isDataProc;
    logic                                     isBranch;
    core_pkg::aluOp_t                         aluOp;
    core_pkg::shiftMode_t                     shiftMode;

    assign instrClass = Instr[`CORE_CLASS_HI:`CORE_CLASS_LO];
    assign opcode     = Instr[`CORE_OPCODE_HI:`CORE_OPCODE_LO];
    assign branchImm  = Instr[`CORE_OFFSET_WIDTH-1:0];
    assign shiftMode  = (instrClass == 3'b001) ? 2'd0 : 2'd3;

    // Class decode with the all-zero word as a NOP
    always_comb begin
        isDataProc = 1'b0;
        isBranch   = 1'b0;
        if (Instr != '0) begin
            case (instrClass)
                3'b000:  isDataProc = ~Instr[`CORE_BIT4_POS]; // Register-specified shift not handled
                3'b001:  isDataProc = 1'b1;
                3'b101:  isBranch = 1'b1;
                default: isDataProc = 1'b0;                   // Load/store and others
            endcase
        end
    end

    // Opcode to internal ALU operation
    always_comb begin
        case (opcode)
            4'h0:    aluOp = 4'd6;  // AND
            4'h1:    aluOp = 4'd8;  // EOR
            4'h2:    aluOp = 4'd2;  // SUB
            4'h3:    aluOp = 4'd4;  // RSB
            4'h4:    aluOp = 4'd0;  // ADD
            4'h5:    aluOp = 4'd1;  // ADC
            4'h6:    aluOp = 4'd3;  // SBC
            4'h7:    aluOp = 4'd5;  // RSC
            4'h8:    aluOp = 4'd6;  // TST
            4'h9:    aluOp = 4'd8;  // TEQ
            4'hA:    aluOp = 4'd2;  // CMP
            4'hB:    aluOp = 4'd0;  // CMN
            4'hC:    aluOp = 4'd7;  // ORR
            4'hD:    aluOp = 4'd10; // MOV
            4'hE:    aluOp = 4'd12; // BIC
            default: aluOp = 4'd11; // MVN
        endcase
    end

    always_ff @(posedge Clk or posedge reset) begin
        if (reset) begin
            DecValid      <= 1'b0;
            DecBranch     <= 1'b0;
            DecAluOp      <= '0;
            DecSetFlags   <= 1'b0;
            DecWrite      <= 1'b0;
            DecShiftMode  <= '0;
            DecShiftField <= '0;
            DecCond       <= '0;
            DecLink       <= 1'b0;
            DecOffset     <= '0;
            DecDest       <= '0;
            DecRn         <= '0;
            DecRm         <= '0;
        end else begin
            DecValid      <= InstrValid & isDataProc;
            DecBranch     <= InstrValid & isBranch;
            DecAluOp      <= aluOp;
            DecSetFlags   <= Instr[`CORE_SBIT_POS];
            DecWrite      <= (opcode[3:2] != 2'b10); // Compare/test ops have no destination
            DecShiftMode  <= shiftMode;
            DecShiftField <= Instr[`CORE_SHIFT_FIELD_WIDTH-1:0];
            DecCond       <= Instr[`CORE_COND_HI:`CORE_COND_LO];
            DecLink       <= Instr[`CORE_LINK_POS];
            // Sign extend and scale by four
            DecOffset     <= {{(`CORE_WORD_WIDTH-`CORE_OFFSET_WIDTH-2){branchImm[`CORE_OFFSET_WIDTH-1]}},
                              branchImm, 2'b00};
            DecDest       <= Instr[`CORE_RD_HI:`CORE_RD_LO];
            DecRn         <= RnValue;
            DecRm         <= RmValue;
        end
    end

endmodule

//--- design/operandShifter.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module operandShifter (
    input  core_pkg::shiftMode_t  DecShiftMode,
    input  core_pkg::shiftField_t DecShiftField,
    input  core_pkg::word_t       DecRm,
    output core_pkg::word_t       Operand2
);

    core_pkg::word_t               immByte;
    logic [4:0]                    rotAmount;
    logic [4:0]                    shiftAmount;
    logic [2*`CORE_WORD_WIDTH-1:0] immRotated;
    logic [2*`CORE_WORD_WIDTH-1:0] rmRotated;

    assign immByte     = {{(`CORE_WORD_WIDTH-8){1'b0}}, DecShiftField[7:0]};
    assign rotAmount   = {DecShiftField[11:8], 1'b0};  // Twice the rotate field
    assign shiftAmount = DecShiftField[11:7];

    // Rotate right by shifting a doubled copy
    assign immRotated = {immByte, immByte} >> rotAmount;
    assign rmRotated  = {DecRm, DecRm} >> shiftAmount;

    always_comb begin
        case (DecShiftMode)
            2'd0: Operand2 = immRotated[`CORE_WORD_WIDTH-1:0];
            2'd3: begin
                case (DecShiftField[6:5])
                    2'b00:   Operand2 = DecRm << shiftAmount;            // LSL
                    2'b01:   Operand2 = DecRm >> shiftAmount;            // LSR
                    2'b10:   Operand2 = $signed(DecRm) >>> shiftAmount;  // ASR
                    default: Operand2 = rmRotated[`CORE_WORD_WIDTH-1:0]; // ROR
                endcase
            end
            default: Operand2 = DecRm;
        endcase
    end

endmodule

//--- design/aluCore.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module aluCore (
    input  logic               Clk,
    input  logic               reset,
    input  logic               DecValid,
    input  core_pkg::aluOp_t   DecAluOp,
    input  logic               DecWrite,
    input  core_pkg::regAddr_t DecDest,
    input  core_pkg::word_t    DecRn,
    input  core_pkg::word_t    Operand2,
    input  core_pkg::flags_t   FlagsIn,
    output core_pkg::flags_t   NextFlags,
    output logic               ResultValid,
    output core_pkg::word_t    Result,
    output core_pkg::regAddr_t DestReg,
    output logic               ResultWrite
);

    localparam int MSB = `CORE_WORD_WIDTH - 1;

    core_pkg::word_t           aluResult;
    core_pkg::word_t           minuend;
    core_pkg::word_t           subtrahend;
    core_pkg::word_t           subResult;
    logic [`CORE_WORD_WIDTH:0] addWide;
    logic                      useCarry;
    logic                      swapOps;
    logic                      subBorrow;
    logic                      nextC;
    logic                      nextV;

    assign useCarry = DecAluOp[0] & FlagsIn[1];             // ADC, SBC, RSC
    assign swapOps  = (DecAluOp == 4'd4) || (DecAluOp == 4'd5);
    assign minuend    = swapOps ? Operand2 : DecRn;
    assign subtrahend = swapOps ? DecRn : Operand2;

    assign addWide   = {1'b0, DecRn} + {1'b0, Operand2} + useCarry;
    assign subResult = minuend - subtrahend - useCarry;
    // Borrow-style carry
    assign subBorrow = {1'b0, minuend} < ({1'b0, subtrahend} + useCarry);

    always_comb begin
        nextC = FlagsIn[1];
        nextV = FlagsIn[0];
        case (DecAluOp)
            4'd0, 4'd1: begin
                aluResult = addWide[MSB:0];
                nextC     = addWide[`CORE_WORD_WIDTH];
                nextV     = ~(DecRn[MSB] ^ Operand2[MSB]) & (DecRn[MSB] ^ aluResult[MSB]);
            end
            4'd2, 4'd3, 4'd4, 4'd5: begin
                aluResult = subResult;
                nextC     = subBorrow;
                nextV     = (minuend[MSB] ^ subtrahend[MSB]) & (minuend[MSB] ^ aluResult[MSB]);
            end
            4'd6:    aluResult = DecRn & Operand2;
            4'd7:    aluResult = DecRn | Operand2;
            4'd8:    aluResult = DecRn ^ Operand2;
            4'd9:    aluResult = DecRn;
            4'd10:   aluResult = Operand2;
            4'd11:   aluResult = ~Operand2;
            4'd12:   aluResult = DecRn & ~Operand2;
            default: aluResult = '0;
        endcase
    end

    assign NextFlags = {aluResult[MSB], (aluResult == '0), nextC, nextV};

    always_ff @(posedge Clk or posedge reset) begin
        if (reset) begin
            ResultValid <= 1'b0;
            Result      <= '0;
            DestReg     <= '0;
            ResultWrite <= 1'b0;
        end else begin
            ResultValid <= DecValid;
            Result      <= aluResult;
            DestReg     <= DecDest;
            ResultWrite <= DecValid & DecWrite;
        end
    end

endmodule

//--- design/conditionUnit.sv
`timescale 1ns/1ps

module conditionUnit (
    input  logic                Clk,
    input  logic                reset,
    input  logic                DecValid,
    input  logic                DecSetFlags,
    input  core_pkg::flags_t    NextFlags,
    input  logic                DecBranch,
    input  core_pkg::condCode_t DecCond,
    input  logic                DecLink,
    input  core_pkg::word_t     DecOffset,
    output core_pkg::flags_t    Flags,
    output logic                BranchTaken,
    output logic                BranchLink,
    output core_pkg::word_t     BranchOffset
);

    logic flagN;
    logic flagZ;
    logic flagC;
    logic flagV;
    logic condPass;

    assign {flagN, flagZ, flagC, flagV} = Flags;

    always_comb begin
        case (DecCond)
            4'h0:    condPass = flagZ;                      // EQ
            4'h1:    condPass = ~flagZ;                     // NE
            4'h2:    condPass = flagC;                      // CS
            4'h3:    condPass = ~flagC;                     // CC
            4'h4:    condPass = flagN;                      // MI
            4'h5:    condPass = ~flagN;                     // PL
            4'h6:    condPass = flagV;                      // VS
            4'h7:    condPass = ~flagV;                     // VC
            4'h8:    condPass = flagC & ~flagZ;             // HI
            4'h9:    condPass = ~flagC | flagZ;             // LS
            4'hA:    condPass = (flagN == flagV);           // GE
            4'hB:    condPass = (flagN != flagV);           // LT
            4'hC:    condPass = ~flagZ & (flagN == flagV);  // GT
            4'hD:    condPass = flagZ | (flagN != flagV);   // LE
            4'hE:    condPass = 1'b1;                       // AL
            default: condPass = 1'b0;
        endcase
    end

    // Status register updated only by flag-setting data ops
    always_ff @(posedge Clk or posedge reset) begin
        if (reset) begin
            Flags <= '0;
        end else if (DecValid && DecSetFlags) begin
            Flags <= NextFlags;
        end
    end

    always_ff @(posedge Clk or posedge reset) begin
        if (reset) begin
            BranchTaken  <= 1'b0;
            BranchLink   <= 1'b0;
            BranchOffset <= '0;
        end else begin
            BranchTaken <= DecBranch & condPass;
            BranchLink  <= DecBranch & condPass & DecLink; // Link only on a taken branch
            if (DecBranch) begin
                BranchOffset <= DecOffset;
            end
        end
    end

endmodule

//--- design/execCore.sv
`timescale 1ns/1ps

module execCore (
    input  logic               Clk,
    input  logic               reset,
    input  logic               InstrValid,
    input  core_pkg::word_t    Instr,
    input  core_pkg::word_t    RnValue,
    input  core_pkg::word_t    RmValue,
    output logic               ResultValid,
    output core_pkg::word_t    Result,
    output core_pkg::regAddr_t DestReg,
    output logic               ResultWrite,
    output core_pkg::flags_t   Flags,
    output logic               BranchTaken,
    output logic               BranchLink,
    output core_pkg::word_t    BranchOffset
);

    // Stage one registers
    logic                  decValid;
    logic                  decBranch;
    core_pkg::aluOp_t      decAluOp;
    logic                  decSetFlags;
    logic                  decWrite;
    core_pkg::shiftMode_t  decShiftMode;
    core_pkg::shiftField_t decShiftField;
    core_pkg::condCode_t   decCond;
    logic                  decLink;
    core_pkg::word_t       decOffset;
    core_pkg::regAddr_t    decDest;
    core_pkg::word_t       decRn;
    core_pkg::word_t       decRm;

    // Stage two combinational paths
    core_pkg::word_t       operand2;
    core_pkg::flags_t      nextFlags;

    instrDecoder instrDecoder_i (
        .Clk(Clk), .reset(reset), .InstrValid(InstrValid), .Instr(Instr),
        .RnValue(RnValue), .RmValue(RmValue),
        .DecValid(decValid), .DecBranch(decBranch), .DecAluOp(decAluOp),
        .DecSetFlags(decSetFlags), .DecWrite(decWrite), .DecShiftMode(decShiftMode),
        .DecShiftField(decShiftField), .DecCond(decCond), .DecLink(decLink),
        .DecOffset(decOffset), .DecDest(decDest), .DecRn(decRn), .DecRm(decRm)
    );

    operandShifter operandShifter_i (
        .DecShiftMode(decShiftMode), .DecShiftField(decShiftField),
        .DecRm(decRm), .Operand2(operand2)
    );

    aluCore aluCore_i (
        .Clk(Clk), .reset(reset), .DecValid(decValid), .DecAluOp(decAluOp),
        .DecWrite(decWrite), .DecDest(decDest), .DecRn(decRn), .Operand2(operand2),
        .FlagsIn(Flags), .NextFlags(nextFlags), .ResultValid(ResultValid),
        .Result(Result), .DestReg(DestReg), .ResultWrite(ResultWrite)
    );

    conditionUnit conditionUnit_i (
        .Clk(Clk), .reset(reset), .DecValid(decValid), .DecSetFlags(decSetFlags),
        .NextFlags(nextFlags), .DecBranch(decBranch), .DecCond(decCond),
        .DecLink(decLink), .DecOffset(decOffset), .Flags(Flags),
        .BranchTaken(BranchTaken), .BranchLink(BranchLink), .BranchOffset(BranchOffset)
    );

endmodule

//--- dv/execCore_tb.sv
`timescale 1ns/1ps

module execCore_tb;

    localparam int ResetCycles = 4;
    localparam int NumArith    = 60;
    localparam int NumLogic    = 40;
    localparam int NumShift    = 10;   // Per shift type
    localparam int NumCompare  = 40;
    localparam int BranchReps  = 4;    // Per condition code
    localparam int StimCycles  = ResetCycles + 8 + NumArith + NumLogic + 4 * NumShift
                                 + NumCompare + 16 * BranchReps * 2 + 8;
    localparam int WatchdogNs  = StimCycles * 10 + 1000;

    // One expected pipeline output set
    typedef struct packed {
        logic        resValid;
        logic [31:0] result;
        logic [3:0]  dest;
        logic        write;
        logic [3:0]  flags;
        logic        branch;
        logic        taken;
        logic        link;
        logic [31:0] offset;
        int          due;
    } expEntry_t;

    logic        Clk;
    logic        reset;
    logic        InstrValid;
    logic [31:0] Instr;
    logic [31:0] RnValue;
    logic [31:0] RmValue;
    logic        ResultValid;
    logic [31:0] Result;
    logic [3:0]  DestReg;
    logic        ResultWrite;
    logic [3:0]  Flags;
    logic        BranchTaken;
    logic        BranchLink;
    logic [31:0] BranchOffset;

    integer      seed;
    int          cycleCount;
    int          errorCount;
    int          checkCount;
    logic [3:0]  modelFlags;   // Flag register of the model
    expEntry_t   expQ[$];
    string       nameQ[$];
    expEntry_t   cur;
    string       curName;

    execCore execCore_i (
        .Clk(Clk), .reset(reset), .InstrValid(InstrValid), .Instr(Instr),
        .RnValue(RnValue), .RmValue(RmValue), .ResultValid(ResultValid),
        .Result(Result), .DestReg(DestReg), .ResultWrite(ResultWrite), .Flags(Flags),
        .BranchTaken(BranchTaken), .BranchLink(BranchLink), .BranchOffset(BranchOffset)
    );

    always #5 Clk = ~Clk;

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
    end

    function automatic logic [31:0] rotateRight(input logic [31:0] value, input int amount);
        if (amount == 0) begin
            return value;
        end
        return (value >> amount) | (value << (32 - amount));
    endfunction

    function automatic logic condHolds(input logic [3:0] cond, input logic [3:0] nzcv);
        logic n;
        logic z;
        logic c;
        logic v;
        {n, z, c, v} = nzcv;
        case (cond)
            4'h0:    return z;
            4'h1:    return !z;
            4'h2:    return c;
            4'h3:    return !c;
            4'h4:    return n;
            4'h5:    return !n;
            4'h6:    return v;
            4'h7:    return !v;
            4'h8:    return c && !z;
            4'h9:    return !c || z;
            4'hA:    return n == v;
            4'hB:    return n != v;
            4'hC:    return !z && (n == v);
            4'hD:    return z || (n != v);
            4'hE:    return 1'b1;
            default: return 1'b0;   // NV never branches
        endcase
    endfunction

    function automatic expEntry_t refExec(input logic valid, input logic [31:0] instr,
                                          input logic [31:0] rn, input logic [31:0] rm,
                                          input logic [3:0] flagsIn);
        expEntry_t   e;
        logic [2:0]  cls;
        logic [3:0]  op;
        logic [31:0] op2;
        logic [31:0] res;
        logic [31:0] minu;
        logic [31:0] subt;
        logic [32:0] wide;
        logic        k;
        logic        c;
        logic        v;
        longint      sres;
        e   = '0;
        cls = instr[27:25];
        op  = instr[24:21];
        c   = flagsIn[1];
        v   = flagsIn[0];
        k   = (op == 4'h5 || op == 4'h6 || op == 4'h7) ? flagsIn[1] : 1'b0; // ADC SBC RSC
        e.flags = flagsIn;
        if (cls == 3'b001) begin
            op2 = rotateRight({24'd0, instr[7:0]}, 2 * instr[11:8]);
        end else begin
            case (instr[6:5])
                2'd0:    op2 = rm << instr[11:7];
                2'd1:    op2 = rm >> instr[11:7];
                2'd2:    op2 = $signed(rm) >>> instr[11:7];
                default: op2 = rotateRight(rm, instr[11:7]);
            endcase
        end
        // RSB and RSC reverse the operands
        minu = (op == 4'h3 || op == 4'h7) ? op2 : rn;
        subt = (op == 4'h3 || op == 4'h7) ? rn : op2;
        case (op)
            4'h0, 4'h8: res = rn & op2;
            4'h1, 4'h9: res = rn ^ op2;
            4'hC:       res = rn | op2;
            4'hD:       res = op2;
            4'hE:       res = rn & ~op2;
            4'hF:       res = ~op2;
            4'h4, 4'h5, 4'hB: begin
                wide = {1'b0, rn} + {1'b0, op2} + {32'd0, k};
                res  = wide[31:0];
                c    = wide[32];
                sres = longint'($signed(rn)) + longint'($signed(op2)) + longint'(k);
                v    = sres != longint'($signed(res));
            end
            default: begin
                res  = minu - subt - {31'd0, k};
                c    = (minu < subt) || (k && minu == subt);  // Borrow style
                sres = longint'($signed(minu)) - longint'($signed(subt)) - longint'(k);
                v    = sres != longint'($signed(res));
            end
        endcase
        if (instr != 32'd0 && ((cls == 3'b000 && !instr[4]) || cls == 3'b001)) begin
            e.resValid = valid;
            e.result   = res;
            e.dest     = instr[15:12];
            e.write    = valid && !(op >= 4'h8 && op <= 4'hB);
            if (valid && instr[20]) begin
                e.flags = {res[31], res == 32'd0, c, v};
            end
        end else if (instr != 32'd0 && cls == 3'b101) begin
            e.branch = valid;
            e.taken  = valid && condHolds(instr[31:28], flagsIn);
            e.link   = e.taken && instr[24];
            e.offset = {{6{instr[23]}}, instr[23:0], 2'b00};
        end
        return e;
    endfunction

    function automatic logic [31:0] dataWord(input logic [2:0] cls, input logic [3:0] op,
                                             input logic s, input logic [3:0] rd,
                                             input logic [11:0] field);
        return {4'hE, cls, op, s, 4'h1, rd, field};
    endfunction

    task automatic reportMismatch(input string name, input string what,
                                  input logic [31:0] expected, input logic [31:0] actual);
        $display("[ERROR] %s %s expected 0x%h actual 0x%h", name, what, expected, actual);
        errorCount++;
    endtask

    task automatic issueInstr(input string name, input logic valid, input logic [31:0] instr,
                              input logic [31:0] rn, input logic [31:0] rm);
        expEntry_t e;
        @(posedge Clk);
        InstrValid <= valid;
        Instr      <= instr;
        RnValue    <= rn;
        RmValue    <= rm;
        e          = refExec(valid, instr, rn, rm, modelFlags);
        e.due      = cycleCount + 3;   // Outputs settle after the second edge
        modelFlags = e.flags;
        expQ.push_back(e);
        nameQ.push_back(name);
    endtask

    // Compare each entry in the cycle it falls due
    always @(negedge Clk) begin
        while (!reset && expQ.size() > 0 && expQ[0].due == cycleCount) begin
            cur     = expQ.pop_front();
            curName = nameQ.pop_front();
            checkCount++;
            if (ResultValid !== cur.resValid) begin
                reportMismatch(curName, "ResultValid", 32'(cur.resValid), 32'(ResultValid));
            end
            if (ResultWrite !== cur.write) begin
                reportMismatch(curName, "ResultWrite", 32'(cur.write), 32'(ResultWrite));
            end
            if (cur.resValid && Result !== cur.result) begin
                reportMismatch(curName, "Result", cur.result, Result);
            end
            if (cur.resValid && DestReg !== cur.dest) begin
                reportMismatch(curName, "DestReg", 32'(cur.dest), 32'(DestReg));
            end
            if (Flags !== cur.flags) begin
                reportMismatch(curName, "Flags", 32'(cur.flags), 32'(Flags));
            end
            if (BranchTaken !== cur.taken) begin
                reportMismatch(curName, "BranchTaken", 32'(cur.taken), 32'(BranchTaken));
            end
            if (BranchLink !== cur.link) begin
                reportMismatch(curName, "BranchLink", 32'(cur.link), 32'(BranchLink));
            end
            if (cur.branch && BranchOffset !== cur.offset) begin
                reportMismatch(curName, "BranchOffset", cur.offset, BranchOffset);
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] rn;
        logic [31:0] rm;
        logic [3:0]  op;
        logic [4:0]  amt;
        int          k;
        seed       = 32'heb8ac6b6;
        Clk        = 1'b0;
        reset      = 1'b1;
        InstrValid = 1'b0;
        Instr      = 32'd0;
        RnValue    = 32'd0;
        RmValue    = 32'd0;
        modelFlags = 4'h0;
        cycleCount = 0;
        errorCount = 0;
        checkCount = 0;
        repeat (ResetCycles) @(posedge Clk);
        reset <= 1'b0;
        @(negedge Clk);
        checkCount++;
        if (ResultValid !== 1'b0) begin
            reportMismatch("reset", "ResultValid", 32'd0, 32'(ResultValid));
        end
        if (ResultWrite !== 1'b0) begin
            reportMismatch("reset", "ResultWrite", 32'd0, 32'(ResultWrite));
        end
        if (BranchTaken !== 1'b0) begin
            reportMismatch("reset", "BranchTaken", 32'd0, 32'(BranchTaken));
        end
        if (BranchLink !== 1'b0) begin
            reportMismatch("reset", "BranchLink", 32'd0, 32'(BranchLink));
        end
        if (Flags !== 4'h0) begin
            reportMismatch("reset", "Flags", 32'd0, 32'(Flags));
        end

        // Words that must not produce any result
        r = $random(seed);
        issueInstr("nopWord", 1'b1, 32'd0, 32'h1234, 32'h5678);
        issueInstr("loadStore", 1'b1, {4'hE, 3'b010, r[24:0]}, r, ~r);
        issueInstr("regShift", 1'b1, dataWord(3'b000, 4'h4, 1'b1, 4'h2, 12'h010), r, r);
        issueInstr("invalidData", 1'b0, dataWord(3'b001, 4'h4, 1'b1, 4'h2, 12'h0FF), r, r);
        issueInstr("invalidBranch", 1'b0, {4'hE, 3'b101, 1'b1, 24'h000010}, r, r);

        for (int i = 0; i < NumArith; i++) begin
            r  = $random(seed);
            rn = $random(seed);
            rm = $random(seed);
            op = 4'h2 + 4'(r % 6);   // SUB RSB ADD ADC SBC RSC
            issueInstr("arith", 1'b1,
                       dataWord(r[8] ? 3'b001 : 3'b000, op, 1'b1, r[24:21], r[20:9] & 12'hFEF),
                       rn, rm);
        end

        for (int i = 0; i < NumLogic; i++) begin
            r  = $random(seed);
            rn = $random(seed);
            k  = int'(r % 6);
            op = (k < 2) ? 4'(k) : 4'(k + 10);   // AND EOR ORR MOV BIC MVN
            issueInstr("logicImm", 1'b1, dataWord(3'b001, op, r[8], r[15:12], r[31:20]), rn, rn);
        end

        for (int typ = 0; typ < 4; typ++) begin
            for (int i = 0; i < NumShift; i++) begin
                r   = $random(seed);
                rn  = $random(seed);
                rm  = $random(seed);
                amt = (i == 0) ? 5'd0 : r[4:0];
                issueInstr($sformatf("shiftType%0d", typ), 1'b1,
                           dataWord(3'b000, r[24:21], r[8], r[15:12], {amt, 2'(typ), 1'b0, 4'h3}),
                           rn, rm);
            end
        end

        // Test and compare ops with a random S bit
        for (int i = 0; i < NumCompare; i++) begin
            r  = $random(seed);
            rn = $random(seed);
            rm = r[3] ? rn : $random(seed);
            issueInstr("compare", 1'b1, dataWord(3'b000, 4'h8 + 4'(r[1:0]), r[2], 4'h6, 12'h002),
                       rn, rm);
        end

        for (int cond = 0; cond < 16; cond++) begin
            for (int i = 0; i < BranchReps; i++) begin
                r  = $random(seed);
                rn = $random(seed);
                rm = r[3] ? rn : $random(seed);
                case (r[5:4])
                    2'd0:    op = 4'hA;
                    2'd1:    op = 4'hB;
                    2'd2:    op = 4'h2;
                    default: op = 4'h4;
                endcase
                issueInstr("flagSet", 1'b1, dataWord(3'b000, op, 1'b1, 4'h5, 12'h002), rn, rm);
                issueInstr($sformatf("branchCond%0d", cond), 1'b1,
                           {4'(cond), 3'b101, r[6], r[31:8]}, 32'd0, 32'd0);
            end
        end

        repeat (4) issueInstr("idle", 1'b0, 32'd0, 32'd0, 32'd0);
        while (expQ.size() > 0) @(negedge Clk);

        $display("Checks: %0d  Errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WatchdogNs);
        $display("Timeout after %0d ns with %0d results still pending", WatchdogNs, expQ.size());
        $display("Checks: %0d  Errors: %0d", checkCount, errorCount);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- flist.f
+incdir+design
design/core_pkg.sv
design/instrDecoder.sv
design/operandShifter.sv
design/aluCore.sv
design/conditionUnit.sv
design/execCore.sv
dv/execCore_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the execCore testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f flist.f --top-module execCore_tb -o execCore_sim

./obj_dir/execCore_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi
exit 0
